// ==== decodeStage.f ====
hdl/decodePkg.sv
hdl/controlDecoder.sv
hdl/immediateUnit.sv
hdl/registerFile.sv
hdl/writeArbiter.sv
hdl/branchResolver.sv
hdl/operandStage.sv
hdl/decodeStage.sv
verification/clockGen.sv
verification/decodeStageTb.sv

// ==== runSim.sh ====
#!/usr/bin/env bash
# Builds the decode stage testbench with Verilator and runs it.
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module decodeStageTb -f decodeStage.f -o decodeSim
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/decodeSim > "$LOG" 2>&1
simStatus=$?
cat "$LOG"
if [ $simStatus -ne 0 ]; then
	echo "simulator exited with status $simStatus"
	exit 1
fi

if grep -qxF '** PASS **' "$LOG"; then
	exit 0
fi
echo "pass line not found in $LOG"
exit 1

// ==== verification/decodeStageTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module decodeStageTb;

	typedef struct packed {
		logic [15:0]         instr;
		logic [15:0]         nextPc;
		decodePkg::fwdBundle fwd;
		decodePkg::wbPort    wb;
		logic                stall;
	} stimT;

	typedef struct packed {
		logic [15:0]        truePc;
		logic               redirect;
		logic               portBusy;
		logic               checkOps;	// op1/op2 known for this entry.
		decodePkg::exBundle ex;
	} expectT;

	localparam decodePkg::fwdBundle noFwd = '0;
	localparam decodePkg::wbPort noWb = '0;

	logic                clk;
	logic                arstN;
	logic                stall;
	logic [15:0]         instr;
	logic [15:0]         nextPc;
	decodePkg::fwdBundle fwd;
	decodePkg::wbPort    wb;
	logic [15:0]         truePc;
	logic                redirect;
	decodePkg::exBundle  exOut;
	logic                portBusy;

	stimT              stims[$];
	expectT            expects[$];
	string             names[$];
	string             curName;
	int                cycles = 0;
	int                cycleLimit = 40;
	integer            seed = 80297;
	logic [15:0]       valA;
	logic [15:0]       valB;
	logic [15:0]       valC;
	logic [15:0]       valPos;
	logic [15:0]       valNeg;
	logic [15:0]       fwdA;
	logic [15:0]       fwdB;
	logic [15:0]       pcTmp;
	logic [15:0]       pcLink;
	logic [7:0]        off8;
	logic [10:0]       off11;
	logic              taken;
	decodePkg::opcodeE brOps [4];
	logic [2:0]        brRegs [3];
	logic [15:0]       brVals [3];

	clockGen clkGen (
		.clk   (clk),
		.arstN (arstN)
	);

	decodeStage UUT (
		.clk      (clk),
		.arstN    (arstN),
		.stall    (stall),
		.instr    (instr),
		.nextPc   (nextPc),
		.fwd      (fwd),
		.wb       (wb),
		.truePc   (truePc),
		.redirect (redirect),
		.exOut    (exOut),
		.portBusy (portBusy)
	);

	////////////////////////////////////////////////////////////////////////////
	// encoding and expected-value helpers
	////////////////////////////////////////////////////////////////////////////

	function automatic logic [15:0] sext5(logic [4:0] v);
		return {{11{v[4]}}, v};
	endfunction

	function automatic logic [15:0] sext8(logic [7:0] v);
		return {{8{v[7]}}, v};
	endfunction

	function automatic logic [15:0] sext11(logic [10:0] v);
		return {{5{v[10]}}, v};
	endfunction

	function automatic logic [15:0] encReg(decodePkg::opcodeE op, logic [2:0] rs,
			logic [2:0] rt, logic [2:0] rd);
		return {op, rs, rt, rd, 2'b00};
	endfunction

	function automatic logic [15:0] encImm5(decodePkg::opcodeE op, logic [2:0] rs,
			logic [2:0] rt, logic [4:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic logic [15:0] encImm8(decodePkg::opcodeE op, logic [2:0] rs,
			logic [7:0] imm);
		return {op, rs, imm};
	endfunction

	function automatic logic [15:0] encImm11(decodePkg::opcodeE op, logic [10:0] imm);
		return {op, imm};
	endfunction

	function automatic logic branchTaken(decodePkg::opcodeE op, logic [15:0] v);
		case (op)
			decodePkg::opBeqz: return v == 16'h0000;
			decodePkg::opBnez: return v != 16'h0000;
			decodePkg::opBltz: return v[15];
			default:           return !v[15];
		endcase
	endfunction

	function automatic decodePkg::fwdBundle makeFwd(logic rsSel, logic [15:0] rsData,
			logic rtSel, logic [15:0] rtData);
		decodePkg::fwdBundle f;
		f.rsSel = rsSel;
		f.rsData = rsData;
		f.rtSel = rtSel;
		f.rtData = rtData;
		return f;
	endfunction

	function automatic decodePkg::wbPort makeWb(logic [2:0] idx, logic [15:0] data);
		decodePkg::wbPort w;
		w.en = 1'b1;
		w.idx = idx;
		w.data = data;
		return w;
	endfunction

	function automatic decodePkg::exBundle makeEx(logic valid, logic halt,
			logic [15:0] op1, logic [15:0] op2, logic [2:0] dstReg, logic regWrite,
			decodePkg::aluOpE aluOp);
		decodePkg::exBundle e;
		e.valid = valid;
		e.halt = halt;
		e.op1 = op1;
		e.op2 = op2;
		e.dstReg = dstReg;
		e.regWrite = regWrite;
		e.aluOp = aluOp;
		return e;
	endfunction

	task automatic addEntry(string name, logic [15:0] instrV, logic [15:0] pcV,
			decodePkg::fwdBundle fwdV, decodePkg::wbPort wbV, logic stallV,
			logic busyV, logic [15:0] truePcV, logic redirectV, logic checkOpsV,
			decodePkg::exBundle exV);
		stimT   s;
		expectT e;
		s.instr = instrV;
		s.nextPc = pcV;
		s.fwd = fwdV;
		s.wb = wbV;
		s.stall = stallV;
		e.truePc = truePcV;
		e.redirect = redirectV;
		e.portBusy = busyV;
		e.checkOps = checkOpsV;
		e.ex = exV;
		if (stallV) begin
			e.ex = expects[$].ex;	// bundle holds under stall.
			e.checkOps = expects[$].checkOps;
		end
		stims.push_back(s);
		expects.push_back(e);
		names.push_back(name);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// checking
	////////////////////////////////////////////////////////////////////////////

	task automatic failWith(string msg);
		$display("%s", msg);
		$display("** FAIL **");
		$fatal(1, "run stopped");
	endtask

	task automatic checkValue(string what, logic [15:0] exp, logic [15:0] act);
		assert (act === exp) else begin
			failWith($sformatf("ERR %s %s expected %h actual %h", curName, what, exp, act));
		end
	endtask

	task automatic checkEx(expectT e);
		checkValue("exOut.valid", 16'(e.ex.valid), 16'(exOut.valid));
		checkValue("exOut.halt", 16'(e.ex.halt), 16'(exOut.halt));
		checkValue("exOut.dstReg", 16'(e.ex.dstReg), 16'(exOut.dstReg));
		checkValue("exOut.regWrite", 16'(e.ex.regWrite), 16'(exOut.regWrite));
		checkValue("exOut.aluOp", 16'(e.ex.aluOp), 16'(exOut.aluOp));
		if (e.checkOps) begin
			checkValue("exOut.op1", e.ex.op1, exOut.op1);
			checkValue("exOut.op2", e.ex.op2, exOut.op2);
		end
	endtask

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= cycleLimit) begin
			failWith($sformatf("simulation timed out after %0d cycles", cycles));
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// table and main loop
	////////////////////////////////////////////////////////////////////////////

	initial begin
		stall = 1'b0;
		instr = encImm11(decodePkg::opNop, 11'h000);
		nextPc = 16'h0000;
		fwd = '0;
		wb = '0;

		valA = 16'($random(seed));
		valB = 16'($random(seed));
		valC = 16'($random(seed));
		valPos = (16'($random(seed)) & 16'h7FFF) | 16'h0001;
		valNeg = 16'($random(seed)) | 16'h8000;
		fwdA = 16'($random(seed));
		fwdB = 16'($random(seed));
		brOps = '{decodePkg::opBeqz, decodePkg::opBnez, decodePkg::opBltz, decodePkg::opBgez};
		brRegs = '{3'd3, 3'd5, 3'd4};
		brVals = '{16'h0000, valPos, valNeg};

		// load registers through the writeback port.
		addEntry("write r1", instr, 16'h0010, noFwd, makeWb(3'd1, valA), 1'b0, 1'b0,
			16'h0010, 1'b0, 1'b1, makeEx(1'b0, 1'b0, 0, 0, 3'd0, 1'b0, decodePkg::aluAdd));
		addEntry("write r2", instr, 16'h0012, noFwd, makeWb(3'd2, valB), 1'b0, 1'b0,
			16'h0012, 1'b0, 1'b1, makeEx(1'b0, 1'b0, 0, 0, 3'd0, 1'b0, decodePkg::aluAdd));
		addEntry("write r4", instr, 16'h0014, noFwd, makeWb(3'd4, valNeg), 1'b0, 1'b0,
			16'h0014, 1'b0, 1'b1, makeEx(1'b0, 1'b0, 0, 0, 3'd0, 1'b0, decodePkg::aluAdd));
		addEntry("write r5", instr, 16'h0016, noFwd, makeWb(3'd5, valPos), 1'b0, 1'b0,
			16'h0016, 1'b0, 1'b1, makeEx(1'b0, 1'b0, 0, 0, 3'd0, 1'b0, decodePkg::aluAdd));
		addEntry("add r1 r2", encReg(decodePkg::opAdd, 3'd1, 3'd2, 3'd6), 16'h0018, noFwd,
			noWb, 1'b0, 1'b0, 16'h0018, 1'b0, 1'b1,
			makeEx(1'b1, 1'b0, valA, valB, 3'd6, 1'b1, decodePkg::aluAdd));
		addEntry("lbi r3", encImm8(decodePkg::opLbi, 3'd3, 8'h9C), 16'h001A, noFwd, noWb,
			1'b0, 1'b0, 16'h001A, 1'b0, 1'b1,
			makeEx(1'b1, 1'b0, 0, sext8(8'h9C), 3'd3, 1'b1, decodePkg::aluPassB));
		addEntry("add forwarded", encReg(decodePkg::opAdd, 3'd1, 3'd2, 3'd5), 16'h001C,
			makeFwd(1'b1, fwdA, 1'b1, fwdB), noWb, 1'b0, 1'b0, 16'h001C, 1'b0, 1'b1,
			makeEx(1'b1, 1'b0, fwdA, fwdB, 3'd5, 1'b1, decodePkg::aluAdd));
		addEntry("addi forwarded", encImm5(decodePkg::opAddi, 3'd2, 3'd4, 5'b10110),
			16'h001E, makeFwd(1'b1, fwdA, 1'b0, 0), noWb, 1'b0, 1'b0, 16'h001E, 1'b0, 1'b1,
			makeEx(1'b1, 1'b0, fwdA, sext5(5'b10110), 3'd4, 1'b1, decodePkg::aluAdd));

		// each branch against zero, positive and negative rs.
		for (int i = 0; i < 4; i++) begin
			for (int j = 0; j < 3; j++) begin
				off8 = 8'($random(seed));
				pcTmp = 16'($random(seed));
				taken = branchTaken(brOps[i], brVals[j]);
				addEntry($sformatf("%s r%0d", brOps[i].name(), brRegs[j]),
					encImm8(brOps[i], brRegs[j], off8), pcTmp, noFwd, noWb, 1'b0, 1'b0,
					taken ? pcTmp + sext8(off8) : pcTmp, taken, 1'b0,
					makeEx(1'b1, 1'b0, 0, 0, 3'd0, 1'b0, decodePkg::aluAdd));
			end
		end

		off11 = 11'($random(seed));
		pcTmp = 16'($random(seed));
		addEntry("j", encImm11(decodePkg::opJ, off11), pcTmp, noFwd, noWb, 1'b0, 1'b0,
			pcTmp + sext11(off11), 1'b1, 1'b0,
			makeEx(1'b1, 1'b0, 0, 0, 3'd0, 1'b0, decodePkg::aluAdd));
		off8 = 8'($random(seed));
		addEntry("jr r5", encImm8(decodePkg::opJr, 3'd5, off8), 16'h0040, noFwd, noWb,
			1'b0, 1'b0, valPos + sext8(off8), 1'b1, 1'b0,
			makeEx(1'b1, 1'b0, 0, 0, 3'd0, 1'b0, decodePkg::aluAdd));
		off11 = 11'($random(seed));
		pcLink = 16'($random(seed));
		addEntry("jal", encImm11(decodePkg::opJal, off11), pcLink, noFwd, noWb, 1'b0, 1'b0,
			pcLink + sext11(off11), 1'b1, 1'b0,
			makeEx(1'b1, 1'b0, 0, 0, 3'd7, 1'b0, decodePkg::aluAdd));
		addEntry("r7 after jal", encReg(decodePkg::opAdd, 3'd7, 3'd0, 3'd1), 16'h0044,
			noFwd, noWb, 1'b0, 1'b0, 16'h0044, 1'b0, 1'b1,
			makeEx(1'b1, 1'b0, pcLink, 0, 3'd1, 1'b1, decodePkg::aluAdd));
		off8 = 8'($random(seed));
		pcLink = 16'($random(seed));
		addEntry("jalr r1", encImm8(decodePkg::opJalr, 3'd1, off8), pcLink, noFwd, noWb,
			1'b0, 1'b0, valA + sext8(off8), 1'b1, 1'b0,
			makeEx(1'b1, 1'b0, 0, 0, 3'd7, 1'b0, decodePkg::aluAdd));
		addEntry("r7 after jalr", encReg(decodePkg::opAdd, 3'd7, 3'd0, 3'd1), 16'h0048,
			noFwd, noWb, 1'b0, 1'b0, 16'h0048, 1'b0, 1'b1,
			makeEx(1'b1, 1'b0, pcLink, 0, 3'd1, 1'b1, decodePkg::aluAdd));

		// link collides with writeback, goes to the hold slot.
		off11 = 11'($random(seed));
		pcLink = 16'($random(seed));
		addEntry("jal with wb", encImm11(decodePkg::opJal, off11), pcLink, noFwd,
			makeWb(3'd6, valC), 1'b0, 1'b0, pcLink + sext11(off11), 1'b1, 1'b0,
			makeEx(1'b1, 1'b0, 0, 0, 3'd7, 1'b0, decodePkg::aluAdd));
		addEntry("hold drain", instr, 16'h0050, noFwd, noWb, 1'b0, 1'b1, 16'h0050, 1'b0,
			1'b1, makeEx(1'b0, 1'b0, 0, 0, 3'd0, 1'b0, decodePkg::aluAdd));
		addEntry("r7 and r6", encReg(decodePkg::opAdd, 3'd7, 3'd6, 3'd2), 16'h0052, noFwd,
			noWb, 1'b0, 1'b0, 16'h0052, 1'b0, 1'b1,
			makeEx(1'b1, 1'b0, pcLink, valC, 3'd2, 1'b1, decodePkg::aluAdd));
		off11 = 11'($random(seed));
		pcTmp = 16'($random(seed));
		addEntry("jal stalled", encImm11(decodePkg::opJal, off11), pcTmp, noFwd, noWb,
			1'b1, 1'b0, pcTmp + sext11(off11), 1'b1, 1'b0, '0);
		addEntry("r7 after stall", encReg(decodePkg::opAdd, 3'd7, 3'd0, 3'd1), 16'h0058,
			noFwd, noWb, 1'b0, 1'b0, 16'h0058, 1'b0, 1'b1,
			makeEx(1'b1, 1'b0, pcLink, 0, 3'd1, 1'b1, decodePkg::aluAdd));
		addEntry("halt", encImm11(decodePkg::opHalt, 11'h000), 16'h005A, noFwd, noWb, 1'b0,
			1'b0, 16'h005A, 1'b0, 1'b1,
			makeEx(1'b1, 1'b1, 0, 0, 3'd0, 1'b0, decodePkg::aluAdd));
		addEntry("nop", instr, 16'h005C, noFwd, noWb, 1'b0, 1'b0, 16'h005C, 1'b0, 1'b1,
			makeEx(1'b0, 1'b0, 0, 0, 3'd0, 1'b0, decodePkg::aluAdd));

		cycleLimit = 2 * stims.size() + 40;

		@(posedge arstN);
		@(negedge clk);
		curName = "reset";
		checkValue("exOut.valid", 16'h0000, 16'(exOut.valid));
		checkValue("exOut.halt", 16'h0000, 16'(exOut.halt));
		checkValue("portBusy", 16'h0000, 16'(portBusy));

		for (int i = 0; i < stims.size(); i++) begin
			@(posedge clk);
			instr <= stims[i].instr;
			nextPc <= stims[i].nextPc;
			fwd <= stims[i].fwd;
			wb <= stims[i].wb;
			stall <= stims[i].stall;
			@(negedge clk);
			if (i > 0) begin
				curName = names[i - 1];	// exOut lags one edge.
				checkEx(expects[i - 1]);
			end
			curName = names[i];
			checkValue("truePc", expects[i].truePc, truePc);
			checkValue("redirect", 16'(expects[i].redirect), 16'(redirect));
			checkValue("portBusy", 16'(expects[i].portBusy), 16'(portBusy));
		end

		@(posedge clk);
		instr <= encImm11(decodePkg::opNop, 11'h000);
		wb <= noWb;
		fwd <= noFwd;
		stall <= 1'b0;
		@(negedge clk);
		curName = names[$];
		checkEx(expects[$]);

		$display("** PASS **");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verification/clockGen.sv ====
`timescale 1ns/1ps
`default_nettype none

module clockGen (
	output logic clk,
	output logic arstN
);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;	// 4 ns period.
	end

	initial begin
		arstN = 1'b0;
		repeat (10) @(posedge clk);
		arstN <= 1'b1;
	end

endmodule

`default_nettype wire

// ==== hdl/decodeStage.sv ====
`timescale 1ns/1ps
`default_nettype none

module decodeStage (
	input  wire logic           clk,
	input  wire logic           arstN,
	input  wire logic           stall,
	input  wire logic [15:0]    instr,
	input  wire logic [15:0]    nextPc,
	input  decodePkg::fwdBundle fwd,
	input  decodePkg::wbPort    wb,
	output logic [15:0]         truePc,
	output logic                redirect,
	output decodePkg::exBundle  exOut,
	output logic                portBusy
);

	decodePkg::ctrlWord ctrl;
	decodePkg::wbPort   regWr;
	logic [15:0]        imm;
	logic [15:0]        imm8;
	logic [15:0]        imm11;
	logic [15:0]        rdA;
	logic [15:0]        rdB;
	logic [15:0]        rsValue;

	controlDecoder uDecoder (
		.instr (instr),
		.ctrl  (ctrl)
	);

	immediateUnit uImm (
		.instr  (instr),
		.immSel (ctrl.immSel),
		.imm    (imm),
		.imm8   (imm8),
		.imm11  (imm11)
	);

	registerFile uRegs (
		.clk     (clk),
		.arstN   (arstN),
		.rdIdxA  (instr[10:8]),	// rs.
		.rdIdxB  (instr[7:5]),	// rt.
		.rdDataA (rdA),
		.rdDataB (rdB),
		.wr      (regWr)
	);

	writeArbiter uArb (
		.clk      (clk),
		.arstN    (arstN),
		.stall    (stall),
		.linkReq  (ctrl.link),
		.linkData (nextPc),
		.wb       (wb),
		.wr       (regWr),
		.portBusy (portBusy)
	);

	operandStage uOperands (
		.clk     (clk),
		.arstN   (arstN),
		.stall   (stall),
		.ctrl    (ctrl),
		.rdA     (rdA),
		.rdB     (rdB),
		.imm     (imm),
		.fwd     (fwd),
		.rsValue (rsValue),
		.exOut   (exOut)
	);

	branchResolver uBranch (
		.ctrl     (ctrl),
		.rsValue  (rsValue),
		.nextPc   (nextPc),
		.imm8     (imm8),
		.imm11    (imm11),
		.truePc   (truePc),
		.redirect (redirect)
	);

endmodule

`default_nettype wire

// ==== hdl/operandStage.sv ====
`timescale 1ns/1ps
`default_nettype none

module operandStage (
	input  wire logic           clk,
	input  wire logic           arstN,
	input  wire logic           stall,
	input  decodePkg::ctrlWord  ctrl,
	input  wire logic [15:0]    rdA,
	input  wire logic [15:0]    rdB,
	input  wire logic [15:0]    imm,
	input  decodePkg::fwdBundle fwd,
	output logic [15:0]         rsValue,
	output decodePkg::exBundle  exOut
);

	logic [15:0]         rtValue;
	logic [15:0]         op2;
	logic                validQ;
	logic                haltQ;
	logic                regWriteQ;
	logic [15:0]         op1Q;
	logic [15:0]         op2Q;
	decodePkg::regIdxT   dstRegQ;
	decodePkg::aluOpE    aluOpQ;

	assign rsValue = fwd.rsSel ? fwd.rsData : rdA;
	assign rtValue = fwd.rtSel ? fwd.rtData : rdB;
	assign op2 = ctrl.useImm ? imm : rtValue;

	////////////////////////////////////////////////////////////////////////////
	// execute bundle register
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			validQ <= 1'b0;
			haltQ <= 1'b0;
			regWriteQ <= 1'b0;
		end else if (!stall) begin
			validQ <= ctrl.valid;
			haltQ <= ctrl.halt;
			regWriteQ <= ctrl.regWrite;
		end
	end

	always_ff @(posedge clk) begin
		if (!stall) begin
			op1Q <= rsValue;
			op2Q <= op2;
			dstRegQ <= ctrl.dstReg;
			aluOpQ <= ctrl.aluOp;
		end
	end

	always_comb begin
		exOut.valid = validQ;
		exOut.halt = haltQ;
		exOut.op1 = op1Q;
		exOut.op2 = op2Q;
		exOut.dstReg = dstRegQ;
		exOut.regWrite = regWriteQ;
		exOut.aluOp = aluOpQ;
	end

endmodule

`default_nettype wire

// ==== hdl/branchResolver.sv ====
`timescale 1ns/1ps
`default_nettype none

module branchResolver (
	input  decodePkg::ctrlWord  ctrl,
	input  wire logic [15:0]    rsValue,
	input  wire logic [15:0]    nextPc,
	input  wire logic [15:0]    imm8,
	input  wire logic [15:0]    imm11,
	output logic [15:0]         truePc,
	output logic                redirect
);

	logic        rsZero;
	logic        condHold;
	logic [15:0] base;
	logic [15:0] offset;
	logic [15:0] target;

	assign rsZero = (rsValue == 16'h0000);

	always_comb begin
		case (ctrl.cond)
			decodePkg::condEqZ: condHold = rsZero;
			decodePkg::condNeZ: condHold = ~rsZero;
			decodePkg::condLtZ: condHold = rsValue[15];	// sign bit.
			default:            condHold = ~rsValue[15];
		endcase
	end

	// register jumps use rs + imm8, pc-relative jumps use imm11.
	assign base = ctrl.jumpReg ? rsValue : nextPc;
	assign offset = (ctrl.jump & ~ctrl.jumpReg) ? imm11 : imm8;
	assign target = base + offset;

	assign redirect = ctrl.jump | (ctrl.branch & condHold);
	assign truePc = redirect ? target : nextPc;

endmodule

`default_nettype wire

// ==== hdl/writeArbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module writeArbiter (
	input  wire logic          clk,
	input  wire logic          arstN,
	input  wire logic          stall,
	input  wire logic          linkReq,
	input  wire logic [15:0]   linkData,
	input  decodePkg::wbPort   wb,
	output decodePkg::wbPort   wr,
	output logic               portBusy
);

	logic        linkTake;
	logic        holdValid;
	logic [15:0] holdData;
	logic        holdLoad;
	logic        holdDrop;

	assign linkTake = linkReq & ~stall;
	assign portBusy = holdValid;

	////////////////////////////////////////////////////////////////////////////
	// port select
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		wr = wb;	// writeback always wins.
		holdLoad = 1'b0;
		holdDrop = 1'b0;
		if (wb.en) begin
			holdLoad = linkTake & ~holdValid;
		end else if (holdValid) begin
			// held link drains first, a new one takes its place.
			wr = '{en: 1'b1, idx: decodePkg::linkReg, data: holdData};
			holdLoad = linkTake;
			holdDrop = ~linkTake;
		end else if (linkTake) begin
			wr = '{en: 1'b1, idx: decodePkg::linkReg, data: linkData};
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// one-entry hold slot
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			holdValid <= 1'b0;
		end else if (holdLoad) begin
			holdValid <= 1'b1;
		end else if (holdDrop) begin
			holdValid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (holdLoad) begin
			holdData <= linkData;
		end
	end

endmodule

`default_nettype wire

// ==== hdl/registerFile.sv ====
`timescale 1ns/1ps
`default_nettype none

module registerFile (
	input  wire logic              clk,
	input  wire logic              arstN,
	input  decodePkg::regIdxT      rdIdxA,
	input  decodePkg::regIdxT      rdIdxB,
	output logic [15:0]            rdDataA,
	output logic [15:0]            rdDataB,
	input  decodePkg::wbPort       wr
);

	logic [15:0] regs [8];

	// no bypass, a write shows up on the next cycle's read.
	assign rdDataA = regs[rdIdxA];
	assign rdDataB = regs[rdIdxB];

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < 8; i++) begin
				regs[i] <= '0;
			end
		end else if (wr.en) begin
			regs[wr.idx] <= wr.data;	// r0 is an ordinary register.
		end
	end

endmodule

`default_nettype wire

// ==== hdl/immediateUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module immediateUnit (
	input  wire logic [15:0]   instr,
	input  decodePkg::immSelE  immSel,
	output logic [15:0]        imm,
	output logic [15:0]        imm8,
	output logic [15:0]        imm11
);

	logic [15:0] imm5Ext;
	logic [15:0] zeroExt;

	assign imm5Ext = {{11{instr[4]}}, instr[4:0]};
	assign imm8 = {{8{instr[7]}}, instr[7:0]};
	assign imm11 = {{5{instr[10]}}, instr[10:0]};
	assign zeroExt = {8'h00, instr[7:0]};

	always_comb begin
		case (immSel)
			decodePkg::imm5:  imm = imm5Ext;
			decodePkg::imm8:  imm = imm8;
			decodePkg::imm11: imm = imm11;
			default:          imm = zeroExt;
		endcase
	end

endmodule

`default_nettype wire

// ==== hdl/controlDecoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module controlDecoder (
	input  wire logic [15:0]      instr,
	output decodePkg::ctrlWord    ctrl
);

	decodePkg::opcodeE opcode;

	assign opcode = decodePkg::opcodeE'(instr[15:11]);

	always_comb begin
		ctrl = '0;
		ctrl.valid = 1'b1;
		ctrl.aluOp = decodePkg::aluAdd;
		ctrl.immSel = decodePkg::imm5;
		ctrl.cond = decodePkg::condEqZ;
		case (opcode)
			decodePkg::opHalt: begin
				ctrl.halt = 1'b1;
			end
			decodePkg::opNop: begin
				ctrl.valid = 1'b0;
			end
			decodePkg::opAddi: begin
				ctrl.regWrite = 1'b1;
				ctrl.dstReg = instr[7:5];
				ctrl.useImm = 1'b1;
				ctrl.immSel = decodePkg::imm5;
			end
			decodePkg::opLbi: begin
				ctrl.regWrite = 1'b1;
				ctrl.dstReg = instr[10:8];	// rs field doubles as dest.
				ctrl.aluOp = decodePkg::aluPassB;
				ctrl.useImm = 1'b1;
				ctrl.immSel = decodePkg::imm8;
			end
			decodePkg::opAdd: begin
				ctrl.regWrite = 1'b1;
				ctrl.dstReg = instr[4:2];
			end
			decodePkg::opBeqz: begin
				ctrl.branch = 1'b1;
				ctrl.cond = decodePkg::condEqZ;
			end
			decodePkg::opBnez: begin
				ctrl.branch = 1'b1;
				ctrl.cond = decodePkg::condNeZ;
			end
			decodePkg::opBltz: begin
				ctrl.branch = 1'b1;
				ctrl.cond = decodePkg::condLtZ;
			end
			decodePkg::opBgez: begin
				ctrl.branch = 1'b1;
				ctrl.cond = decodePkg::condGeZ;
			end
			decodePkg::opJ: begin
				ctrl.jump = 1'b1;
			end
			decodePkg::opJr: begin
				ctrl.jump = 1'b1;
				ctrl.jumpReg = 1'b1;
			end
			// link goes through the arbiter, so no regWrite here.
			decodePkg::opJal: begin
				ctrl.jump = 1'b1;
				ctrl.link = 1'b1;
				ctrl.dstReg = decodePkg::linkReg;
			end
			decodePkg::opJalr: begin
				ctrl.jump = 1'b1;
				ctrl.jumpReg = 1'b1;
				ctrl.link = 1'b1;
				ctrl.dstReg = decodePkg::linkReg;
			end
			default: begin
				ctrl.valid = 1'b0;	// unsupported opcode acts as nop.
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== hdl/decodePkg.sv ====
`default_nettype none

package decodePkg;

	////////////////////////////////////////////////////////////////////////////
	// instruction fields
	////////////////////////////////////////////////////////////////////////////

	typedef enum logic [4:0] {
		opHalt = 5'b00000,
		opNop  = 5'b00001,
		opJ    = 5'b00100,
		opJr   = 5'b00101,
		opJal  = 5'b00110,
		opJalr = 5'b00111,
		opAddi = 5'b01000,
		opBeqz = 5'b01100,
		opBnez = 5'b01101,
		opBltz = 5'b01110,
		opBgez = 5'b01111,
		opLbi  = 5'b11000,
		opAdd  = 5'b11011
	} opcodeE;

	typedef logic [2:0] regIdxT;

	localparam regIdxT linkReg = 3'd7;	// jal/jalr target register.

	typedef enum logic [1:0] {
		aluAdd   = 2'b00,
		aluPassB = 2'b01
	} aluOpE;

	typedef enum logic [1:0] {
		imm5    = 2'b00,
		imm8    = 2'b01,
		imm11   = 2'b10,
		immZero = 2'b11
	} immSelE;

	typedef enum logic [1:0] {
		condEqZ = 2'b00,
		condNeZ = 2'b01,
		condLtZ = 2'b10,
		condGeZ = 2'b11
	} condE;

	////////////////////////////////////////////////////////////////////////////
	// stage bundles
	////////////////////////////////////////////////////////////////////////////

	typedef struct packed {
		logic   valid;
		logic   halt;
		logic   regWrite;
		regIdxT dstReg;
		aluOpE  aluOp;
		logic   useImm;
		immSelE immSel;
		logic   branch;
		condE   cond;
		logic   jump;
		logic   jumpReg;	// base is rs, not nextPc.
		logic   link;
	} ctrlWord;

	typedef struct packed {
		logic        rsSel;
		logic [15:0] rsData;
		logic        rtSel;
		logic [15:0] rtData;
	} fwdBundle;

	typedef struct packed {
		logic        en;
		regIdxT      idx;
		logic [15:0] data;
	} wbPort;

	typedef struct packed {
		logic        valid;
		logic        halt;
		logic [15:0] op1;
		logic [15:0] op2;
		regIdxT      dstReg;
		logic        regWrite;
		aluOpE       aluOp;
	} exBundle;

endpackage

`default_nettype wire
